// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing
TOP       = fetch_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Verification failed
PASS_MSG  = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	// opcodes the front end knows about
	localparam logic [5:0] OP_J    = 6'd2; // unconditional jump
	localparam logic [5:0] OP_ADDI = 6'd8; // add immediate, boot image only

	// I-type layout
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} inst_i_t;

	// J-type layout
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target; // word address
	} inst_j_t;

	// one instruction word, two decodes of the same 32 bits
	typedef union packed {
		inst_i_t itype;
		inst_j_t jtype;
	} inst_word_t;

	// byte from the uart receiver
	typedef struct packed {
		logic [7:0] data;
		logic       ready; // one cycle per byte
	} loader_byte_t;

	// fetch result back to the sequencer and out of the top
	typedef struct packed {
		inst_word_t inst;
		logic       distinct; // pc moved last cycle
	} fetch_out_t;

	// boot program, r1 counts up then loops on words 2 and 3
	localparam logic [31:0] BOOT_IMAGE [4] = '{
		{OP_ADDI, 5'd1, 5'd1, 16'd1}, // addi r1 r1 1
		{OP_ADDI, 5'd1, 5'd1, 16'd2}, // addi r1 r1 2
		{OP_ADDI, 5'd1, 5'd1, 16'd1}, // addi r1 r1 1
		{OP_J, 26'd2}                 // j 2, also fills every higher address
	};

endpackage

// ==== hdl/fetch_top.sv ====
module fetch_top #(
	parameter int ADDR_WIDTH   = 4,
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic                   rx,    // serial program, idle high
	input  logic                   load,  // loader enable level
	input  logic                   step,  // advance pc
	output fetch_pkg::inst_word_t  inst,
	output logic                   distinct,
	output logic [ADDR_WIDTH-1:0]  pc
);
	import fetch_pkg::*;

	loader_byte_t rx_byte; // receiver to loader
	fetch_out_t   fetched; // memory to sequencer and outputs

	// serial line to bytes
	uart_byte_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_byte_rx_i (
		.CLK     (CLK),
		.reset   (reset),
		.rx      (rx),
		.rx_byte (rx_byte)
	);

	// program counter
	pc_sequencer #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) pc_sequencer_i (
		.CLK     (CLK),
		.reset   (reset),
		.step    (step),
		.fetched (fetched),
		.pc      (pc)
	);

	// store plus byte loader
	inst_memory #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) inst_memory_i (
		.CLK     (CLK),
		.reset   (reset),
		.pc      (pc),
		.rx_byte (rx_byte),
		.load    (load),
		.fetched (fetched)
	);

	// split the fetch bundle
	assign inst     = fetched.inst;
	assign distinct = fetched.distinct;

endmodule

// ==== hdl/inst_memory.sv ====
module inst_memory #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                     CLK,
	input  logic                     reset,
	input  logic [ADDR_WIDTH-1:0]    pc,
	input  fetch_pkg::loader_byte_t  rx_byte,
	input  logic                     load,
	output fetch_pkg::fetch_out_t    fetched
);
	import fetch_pkg::*;

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_BYTE0,
		LD_BYTE1,
		LD_BYTE2,
		LD_BYTE3,
		LD_WRITE
	} ld_state_t;

	inst_word_t            mem [DEPTH];
	inst_word_t            inst_q;      // registered read data
	logic                  distinct_q;
	logic [ADDR_WIDTH:0]   pc_buffer;   // extra msb so reset never matches a pc
	ld_state_t             ld_state;
	logic [ADDR_WIDTH-1:0] ld_index;    // next word to write
	logic [3:0][7:0]       ld_buf;      // word under assembly
	logic                  ld_write;

	assign ld_write = (ld_state == LD_WRITE);

	// loader control, dropping load wins over every state
	always_ff @(posedge CLK) begin
		if (reset) begin
			ld_state <= LD_IDLE;
			ld_index <= '0;
		end else if (!load) begin
			ld_state <= LD_IDLE; // partial word is lost
			ld_index <= '0;
		end else begin
			case (ld_state)
				LD_IDLE:  ld_state <= LD_BYTE0;
				LD_BYTE0: if (rx_byte.ready) ld_state <= LD_BYTE1;
				LD_BYTE1: if (rx_byte.ready) ld_state <= LD_BYTE2;
				LD_BYTE2: if (rx_byte.ready) ld_state <= LD_BYTE3;
				LD_BYTE3: if (rx_byte.ready) ld_state <= LD_WRITE;
				LD_WRITE: begin
					ld_state <= LD_BYTE0; // straight on to the next word
					ld_index <= ld_index + 1'b1;
				end
				default:  ld_state <= LD_IDLE;
			endcase
		end
	end

	// byte lanes, lsb first
	always_ff @(posedge CLK) begin
		if (rx_byte.ready) begin
			case (ld_state)
				LD_BYTE0: ld_buf[0] <= rx_byte.data;
				LD_BYTE1: ld_buf[1] <= rx_byte.data;
				LD_BYTE2: ld_buf[2] <= rx_byte.data;
				LD_BYTE3: ld_buf[3] <= rx_byte.data;
				default: ;
			endcase
		end
	end

	// store, boot image on reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= BOOT_IMAGE[(i < 4) ? i : 3]; // upper words all jump to 2
		end else if (ld_write) begin
			mem[ld_index] <= ld_buf; // full word even if load just fell
		end
	end

	// read port, old word on a same-cycle write
	always_ff @(posedge CLK) begin
		inst_q <= mem[pc];
	end

	// change detect on pc
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc_buffer  <= '1; // msb set, first compare after reset differs
			distinct_q <= 1'b0;
		end else begin
			distinct_q <= ({1'b0, pc} != pc_buffer);
			pc_buffer  <= {1'b0, pc};
		end
	end

	assign fetched = '{inst: inst_q, distinct: distinct_q};

endmodule

// ==== hdl/pc_sequencer.sv ====
module pc_sequencer #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic                   step,
	input  fetch_pkg::fetch_out_t  fetched,
	output logic [ADDR_WIDTH-1:0]  pc
);
	import fetch_pkg::*;

	logic                  is_jump;  // current word is j
	logic [ADDR_WIDTH-1:0] seq_pc;   // pc + 1, wraps
	logic [ADDR_WIDTH-1:0] jump_pc;  // low bits of the j target
	logic [ADDR_WIDTH-1:0] next_pc;

	// opcode sits in the same bits for both layouts
	// test it through the I-type view first
	assign is_jump = (fetched.inst.itype.opcode == OP_J);

	// sequential successor
	assign seq_pc = pc + 1'b1;

	// target is a word address, keep what fits the memory
	always_comb begin
		jump_pc = '0;
		if (is_jump)
			jump_pc = fetched.inst.jtype.target[ADDR_WIDTH-1:0];
	end

	assign next_pc = is_jump ? jump_pc : seq_pc;

	// pc moves only on a step strobe
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0; // boot from word 0
		end else if (step) begin
			pc <= next_pc;
		end
	end

endmodule

// ==== hdl/uart_byte_rx.sv ====
module uart_byte_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  rx,
	output fetch_pkg::loader_byte_t rx_byte
);

	// counter wide enough for a full bit period
	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;    // first sync stage
	logic             rx_sync;    // safe to use
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;    // data bit being sampled
	logic [7:0]       shift_reg;
	logic             ready_q;
	logic             sample_data;

	// line idles high, so sync flops reset to 1
	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// centre of a data bit
	assign sample_data = (state == RX_DATA) && (baud_cnt == CNT_FULL);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			ready_q  <= 1'b0;
		end else begin
			ready_q <= 1'b0; // strobe, one cycle only
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync)
						state <= RX_START; // falling edge, maybe a start bit
				end
				RX_START: begin
					if (baud_cnt == CNT_HALF) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						// still low at mid-bit, otherwise a glitch
						state    <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (baud_cnt == CNT_FULL) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (baud_cnt == CNT_FULL) begin
						ready_q <= rx_sync; // bad stop bit drops the frame
						state   <= RX_IDLE;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge CLK) begin
		if (sample_data)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	assign rx_byte = '{data: shift_reg, ready: ready_q};

endmodule

// ==== testbench/fetch_tb.sv ====
module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	localparam int ADDR_WIDTH    = 4;
	localparam int CLKS_PER_BIT  = 8;
	localparam int DEPTH         = 2 ** ADDR_WIDTH;
	localparam int READY_TIMEOUT = 4 * CLKS_PER_BIT; // cycles from stop bit to strobe

	logic                  CLK;
	logic                  reset;
	logic                  rx;
	logic                  load;
	logic                  step;
	inst_word_t            inst;
	logic                  distinct;
	logic [ADDR_WIDTH-1:0] pc;

	// reference model of the store, loader and pc
	logic [31:0]           model_mem [DEPTH];
	logic [ADDR_WIDTH-1:0] model_pc;
	logic [3:0][7:0]       model_buf;  // word under assembly
	logic [1:0]            byte_cnt;   // next lane, wraps after four
	logic [ADDR_WIDTH-1:0] write_idx;  // next word address
	logic                  model_load;

	fetch_top #(
		.ADDR_WIDTH   (ADDR_WIDTH),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) fetch_top_i (
		.CLK      (CLK),
		.reset    (reset),
		.rx       (rx),
		.load     (load),
		.step     (step),
		.inst     (inst),
		.distinct (distinct),
		.pc       (pc)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK; // 40 ns period
	end

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "run stopped at time %0t", $time);
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at time %0t: %s, got %h, expected %h",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	// loader rule, lsb first, four bytes per word
	task automatic absorb_byte(input logic [7:0] data);
		if (model_load) begin
			model_buf[byte_cnt] = data;
			if (byte_cnt == 2'd3) begin
				model_mem[write_idx] = model_buf;
				write_idx++; // wraps with the memory
			end
			byte_cnt++;
		end
	endtask

	// one 8N1 frame, then wait for the receiver strobe
	task automatic send_byte(input logic [7:0] data);
		logic [8:0] frame;
		logic       got;
		int         waited;
		frame = {data, 1'b0}; // start bit goes out first
		for (int i = 0; i < 9; i++) begin
			@(posedge CLK);
			rx <= frame[0];
			frame = frame >> 1;
			repeat (CLKS_PER_BIT - 1) @(posedge CLK);
		end
		@(posedge CLK);
		rx <= 1'b1; // stop bit, line stays idle after it
		got = 1'b0;
		waited = 0;
		while (!got) begin
			@(negedge CLK);
			got = fetch_top_i.rx_byte.ready;
			waited++;
			if (!got && waited > READY_TIMEOUT) begin
				$display("timeout: the receiver gave no ready strobe for byte %h", data);
				abort_run();
			end
		end
		check_equal(32'(fetch_top_i.rx_byte.data), 32'(data), "received byte");
		absorb_byte(data);
		repeat (2) @(posedge CLK); // loader writes a full word here
	endtask

	task automatic send_word(input logic [31:0] word);
		logic [31:0] rest;
		rest = word;
		for (int i = 0; i < 4; i++) begin
			send_byte(rest[7:0]);
			rest = rest >> 8;
		end
	endtask

	task automatic set_load(input logic level);
		@(posedge CLK);
		load <= level;
		model_load = level;
		if (!level) begin
			byte_cnt  = '0; // partial word thrown away
			write_idx = '0;
		end
		repeat (2) @(posedge CLK); // loader reaches collect or idle
	endtask

	// jump takes the low target bits, anything else counts up
	function automatic logic [ADDR_WIDTH-1:0] next_pc_of(input logic [ADDR_WIDTH-1:0] addr);
		logic [31:0] w;
		w = model_mem[addr];
		if (w[31:26] == OP_J)
			return w[ADDR_WIDTH-1:0];
		return addr + 1'b1;
	endfunction

	task automatic step_and_check();
		logic [ADDR_WIDTH-1:0] expect_pc;
		logic                  moved;
		expect_pc = next_pc_of(model_pc);
		moved     = (expect_pc != model_pc);
		@(posedge CLK);
		step <= 1'b1;
		@(posedge CLK);
		step <= 1'b0;
		model_pc = expect_pc;
		@(negedge CLK);
		check_equal(32'(pc), 32'(model_pc), "pc after step");
		check_equal(32'(distinct), 32'd0, "distinct before the new fetch");
		@(negedge CLK);
		check_equal(32'(distinct), 32'(moved), "distinct after pc change");
		check_equal(inst, model_mem[model_pc], "fetched instruction");
		@(negedge CLK);
		check_equal(32'(distinct), 32'd0, "distinct with pc held");
		check_equal(inst, model_mem[model_pc], "instruction held");
	endtask

	function automatic logic [31:0] random_plain_word();
		logic [31:0] w;
		w = $urandom;
		if (w[31:26] == OP_J)
			w[31:26] = OP_ADDI; // keeps the pc stepping in order
		return w;
	endfunction

	function automatic logic [31:0] random_jump_word();
		return {OP_J, 26'($urandom)};
	endfunction

	initial begin
		int n_bytes;
		void'($urandom(12));
		reset = 1'b1;
		rx    = 1'b1;
		load  = 1'b0;
		step  = 1'b0;
		for (int i = 0; i < DEPTH; i++)
			model_mem[ADDR_WIDTH'(i)] = BOOT_IMAGE[(i < 4) ? 2'(i) : 2'd3];
		model_pc   = '0;
		model_buf  = '0;
		byte_cnt   = '0;
		write_idx  = '0;
		model_load = 1'b0;

		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		check_equal(32'(distinct), 32'd1, "distinct pulse after reset");
		check_equal(32'(pc), 32'd0, "pc after reset");
		check_equal(inst, model_mem[0], "boot word 0");
		@(negedge CLK);
		check_equal(32'(distinct), 32'd0, "distinct after reset pulse");

		// boot image, 0 1 2 3 then loops on 2 3
		repeat (8) step_and_check();

		// full load of plain words, then walk every address
		set_load(1'b1);
		for (int i = 0; i < DEPTH; i++)
			send_word(random_plain_word());
		set_load(1'b0);
		repeat (DEPTH) step_and_check();

		// frames with load low are dropped
		repeat (4) send_byte(8'($urandom));
		repeat (DEPTH) step_and_check();

		// abort mid word, earlier contents must survive
		n_bytes = 1 + int'($urandom_range(2));
		set_load(1'b1);
		send_word(random_plain_word());
		repeat (n_bytes) send_byte(8'($urandom));
		set_load(1'b0);
		repeat (DEPTH) step_and_check();
		set_load(1'b1);
		send_word(random_plain_word()); // restarts at address 0
		set_load(1'b0);
		repeat (DEPTH) step_and_check();

		// program with random jumps
		set_load(1'b1);
		for (int i = 0; i < DEPTH; i++) begin
			if ($urandom_range(2) == 0)
				send_word(random_jump_word());
			else
				send_word(random_plain_word());
		end
		set_load(1'b0);
		repeat (40) step_and_check();

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
hdl/fetch_pkg.sv
hdl/uart_byte_rx.sv
hdl/pc_sequencer.sv
hdl/inst_memory.sv
hdl/fetch_top.sv
testbench/fetch_tb.sv
